//--- include/pipe_defs.svh
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

`define ISA_WIDTH       32          // data and instruction word
`define REG_ADDR_WIDTH  5           // 32 general registers
`define ROM_DEPTH       8           // word address bits, 256 words

`define OP_WIDTH        6           // opcode field, bits 31:26
`define FUNC_WIDTH      6           // func field, bits 5:0
`define IMM_WIDTH       16          // i-type immediate
`define JIDX_WIDTH      26          // j-type instruction index
`define RS_LSB          21          // rs field 25:21
`define RT_LSB          16          // rt field 20:16
`define RD_LSB          11          // rd field 15:11
`define LINK_REG        5'd31       // jal return register

`define OP_RTYPE        6'h00
`define OP_J            6'h02
`define OP_JAL          6'h03
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_ADDI         6'h08
`define OP_LW           6'h23
`define OP_SW           6'h2b

`define FUNC_JR         6'h08
`define FUNC_ADD        6'h20
`define FUNC_SUB        6'h22
`define FUNC_AND        6'h24
`define FUNC_OR         6'h25
`define FUNC_SLT        6'h2a

`endif

//--- hdl/pipe_pkg.sv
`include "pipe_defs.svh"

package pipe_pkg;

    typedef logic [`ISA_WIDTH-1:0]      word_t;       // data or instruction
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;    // register index
    typedef logic [`ROM_DEPTH-1:0]      imem_addr_t;  // rom word address

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass                                       // operand_1 straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_ctrl_t;

    typedef struct packed {
        logic r_type;                                  // alu reg-reg
        logic i_type;                                  // addi, lw, sw
        logic j;
        logic jr;
        logic jal;
        logic branch_eq;
        logic branch_ne;
        logic store;
        logic load;
    } inst_class_t;

    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
    } wb_bus_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        mem_ctrl_t mem_ctrl;
        logic      wb_en;
        word_t     operand_1;
        word_t     operand_2;
        word_t     store_data;
        reg_idx_t  rs_idx;                             // for forwarding downstream
        reg_idx_t  rt_idx;
        reg_idx_t  dest_idx;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

//--- hdl/instruction_mem.sv
`include "pipe_defs.svh"
`timescale 1ns/1ps

module instruction_mem (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_mode,            // loader owns the rom
    input  logic                load_we,
    input  pipe_pkg::imem_addr_t load_addr,
    input  pipe_pkg::word_t     load_data,
    input  pipe_pkg::redirect_t redirect,             // from decode
    input  logic                hold,                 // from hazard unit
    output pipe_pkg::word_t     if_pc,                // pc + 4
    output pipe_pkg::word_t     if_instruction,
    output logic                if_no_op
);

    pipe_pkg::word_t rom [0:(1 << `ROM_DEPTH)-1];    // program store
    pipe_pkg::word_t pc;
    pipe_pkg::word_t pc_next;
    logic            load_mode_q;                     // last cycle's load_mode
    logic            load_done;                       // falling edge of load_mode

    assign load_done = load_mode_q & ~load_mode;

    // loader port, word granular
    always_ff @(posedge clk) begin
        if (load_we) begin
            rom[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_mode_q <= 1'b0;
        end else begin
            load_mode_q <= load_mode;
        end
    end

    always_comb begin
        if (load_done) begin
            pc_next = '0;                             // restart program after load
        end else if (redirect.taken) begin
            pc_next = redirect.target;
        end else if (hold) begin
            pc_next = pc;                             // back-pressure, refetch
        end else begin
            pc_next = if_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign if_pc          = pc + 32'd4;
    assign if_instruction = rom[pc[`ROM_DEPTH+1:2]]; // async read, word addressed
    // pc is stale until the restart edge, so the fall cycle is blanked too
    assign if_no_op       = load_mode | load_done;

endmodule

//--- hdl/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            hold,                     // keep current entry
    input  logic            squash,                   // redirect taken in id
    input  pipe_pkg::word_t if_pc,
    input  pipe_pkg::word_t if_instruction,
    input  logic            if_no_op,
    output pipe_pkg::word_t id_pc,
    output pipe_pkg::word_t id_instruction,
    output logic            id_no_op
);

    // control bit, squash beats hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_no_op <= 1'b1;                         // start empty
        end else if (squash) begin
            id_no_op <= 1'b1;                         // kill the wrong-path fetch
        end else if (!hold) begin
            id_no_op <= if_no_op;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (squash) begin
            id_instruction <= '0;
            id_pc          <= if_pc;
        end else if (!hold) begin
            id_instruction <= if_instruction;
            id_pc          <= if_pc;
        end
    end

endmodule

//--- hdl/register_file.sv
`include "pipe_defs.svh"
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              arst_n,
    input  pipe_pkg::reg_idx_t rs_idx,
    input  pipe_pkg::reg_idx_t rt_idx,
    input  pipe_pkg::wb_bus_t wb,                     // write-back from outside
    output pipe_pkg::word_t   rs_data,
    output pipe_pkg::word_t   rt_data
);

    localparam int REG_COUNT = 1 << `REG_ADDR_WIDTH;

    pipe_pkg::word_t regs [0:REG_COUNT-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;                 // r0 stays zero
        end
    end

    // write-through bypass beats the array
    function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_idx_t idx);
        pipe_pkg::word_t value;
        if (idx == '0) begin
            value = '0;                               // hardwired zero
        end else if (wb.en && wb.addr == idx) begin
            value = wb.data;                          // bypass
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // re-evaluated on wb and regs too, not only on the indices
    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

endmodule

//--- hdl/control.sv
`include "pipe_defs.svh"
`timescale 1ns/1ps

module control (
    input  pipe_pkg::word_t       id_instruction,
    output pipe_pkg::inst_class_t inst_class,
    output pipe_pkg::alu_op_t     alu_op,
    output pipe_pkg::mem_ctrl_t   mem_ctrl,
    output logic                  wb_en
);

    logic [`OP_WIDTH-1:0]   opcode;
    logic [`FUNC_WIDTH-1:0] func;
    pipe_pkg::reg_idx_t     rt_field;
    pipe_pkg::reg_idx_t     rd_field;

    assign opcode   = id_instruction[`ISA_WIDTH-1 -: `OP_WIDTH];  // op 31:26
    assign func     = id_instruction[`FUNC_WIDTH-1:0];
    assign rt_field = id_instruction[`RT_LSB +: `REG_ADDR_WIDTH];
    assign rd_field = id_instruction[`RD_LSB +: `REG_ADDR_WIDTH];

    always_comb begin
        inst_class = '0;                              // unknown decodes as bubble
        alu_op     = pipe_pkg::alu_pass;
        mem_ctrl   = pipe_pkg::mem_none;
        case (opcode)
            `OP_RTYPE: begin
                case (func)
                    `FUNC_ADD: begin
                        inst_class.r_type = 1'b1;
                        alu_op            = pipe_pkg::alu_add;
                    end
                    `FUNC_SUB: begin
                        inst_class.r_type = 1'b1;
                        alu_op            = pipe_pkg::alu_sub;
                    end
                    `FUNC_AND: begin
                        inst_class.r_type = 1'b1;
                        alu_op            = pipe_pkg::alu_and;
                    end
                    `FUNC_OR: begin
                        inst_class.r_type = 1'b1;
                        alu_op            = pipe_pkg::alu_or;
                    end
                    `FUNC_SLT: begin
                        inst_class.r_type = 1'b1;
                        alu_op            = pipe_pkg::alu_slt;
                    end
                    `FUNC_JR: inst_class.jr = 1'b1;   // resolved here, alu idle
                    default: ;
                endcase
            end
            `OP_ADDI: begin
                inst_class.i_type = 1'b1;
                alu_op            = pipe_pkg::alu_add;
            end
            `OP_LW: begin
                inst_class.i_type = 1'b1;
                inst_class.load   = 1'b1;
                alu_op            = pipe_pkg::alu_add;  // address = rs + imm
                mem_ctrl          = pipe_pkg::mem_load;
            end
            `OP_SW: begin
                inst_class.i_type = 1'b1;
                inst_class.store  = 1'b1;
                alu_op            = pipe_pkg::alu_add;
                mem_ctrl          = pipe_pkg::mem_store;
            end
            `OP_BEQ: inst_class.branch_eq = 1'b1;
            `OP_BNE: inst_class.branch_ne = 1'b1;
            `OP_J:   inst_class.j         = 1'b1;
            `OP_JAL: inst_class.jal       = 1'b1;   // link value passes through
            default: ;
        endcase
    end

    // results aimed at r0 are dropped here so nothing downstream writes it
    assign wb_en = (inst_class.r_type && rd_field != '0)
                 || (inst_class.i_type && !inst_class.store && rt_field != '0)
                 || inst_class.jal;

endmodule

//--- hdl/operand_select.sv
`include "pipe_defs.svh"
`timescale 1ns/1ps

module operand_select (
    input  pipe_pkg::inst_class_t inst_class,
    input  pipe_pkg::word_t       id_pc,              // already pc + 4
    input  pipe_pkg::word_t       id_instruction,
    input  logic                  id_no_op,
    input  pipe_pkg::word_t       rs_data,
    input  pipe_pkg::word_t       rt_data,
    output pipe_pkg::redirect_t   redirect,
    output pipe_pkg::word_t       operand_1,
    output pipe_pkg::word_t       operand_2,
    output pipe_pkg::word_t       store_data,
    output pipe_pkg::reg_idx_t    rs_idx_out,
    output pipe_pkg::reg_idx_t    rt_idx_out,
    output pipe_pkg::reg_idx_t    dest_idx
);

    pipe_pkg::word_t    imm_ext;
    pipe_pkg::word_t    branch_target;
    pipe_pkg::word_t    jump_target;
    pipe_pkg::reg_idx_t rs_field;
    pipe_pkg::reg_idx_t rt_field;
    pipe_pkg::reg_idx_t rd_field;
    logic               cond_ok;                      // branch condition holds

    assign rs_field = id_instruction[`RS_LSB +: `REG_ADDR_WIDTH];
    assign rt_field = id_instruction[`RT_LSB +: `REG_ADDR_WIDTH];
    assign rd_field = id_instruction[`RD_LSB +: `REG_ADDR_WIDTH];

    assign imm_ext = {{(`ISA_WIDTH-`IMM_WIDTH){id_instruction[`IMM_WIDTH-1]}},
                      id_instruction[`IMM_WIDTH-1:0]};
    assign branch_target = id_pc + (imm_ext << 2);   // relative to pc + 4
    assign jump_target   = {id_pc[`ISA_WIDTH-1 -: 4], id_instruction[`JIDX_WIDTH-1:0], 2'b00};

    assign cond_ok = (inst_class.branch_eq && rs_data == rt_data)
                   || (inst_class.branch_ne && rs_data != rt_data);

    always_comb begin
        redirect.taken = !id_no_op
                       && (cond_ok || inst_class.j || inst_class.jal || inst_class.jr);
        if (inst_class.jr) begin
            redirect.target = rs_data;
        end else if (inst_class.j || inst_class.jal) begin
            redirect.target = jump_target;
        end else begin
            redirect.target = branch_target;
        end
    end

    always_comb begin
        operand_1  = '0;
        operand_2  = '0;
        store_data = '0;
        rs_idx_out = '0;                              // zero = no source
        rt_idx_out = '0;
        dest_idx   = '0;                              // zero = no result
        if (inst_class.r_type) begin
            operand_1  = rs_data;
            operand_2  = rt_data;
            rs_idx_out = rs_field;
            rt_idx_out = rt_field;
            dest_idx   = rd_field;
        end else if (inst_class.i_type) begin
            operand_1  = rs_data;
            operand_2  = imm_ext;
            rs_idx_out = rs_field;
            if (inst_class.store) begin
                store_data = rt_data;
                rt_idx_out = rt_field;                // store data still needs forwarding
            end else begin
                dest_idx   = rt_field;                // addi, lw
            end
        end else if (inst_class.jal) begin
            operand_1 = id_pc;                        // return address
            dest_idx  = `LINK_REG;
        end else if (inst_class.branch_eq || inst_class.branch_ne) begin
            rs_idx_out = rs_field;
            rt_idx_out = rt_field;
        end else if (inst_class.jr) begin
            rs_idx_out = rs_field;
        end
    end

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             hold,                    // stall from hazard unit
    input  pipe_pkg::id_ex_t decoded,                 // valid low for a no-op
    output pipe_pkg::id_ex_t id_ex
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (hold || !decoded.valid) begin
            id_ex <= '0;                              // bubble, all controls off
        end else begin
            id_ex <= decoded;
        end
    end

endmodule

//--- hdl/front_end_top.sv
`include "pipe_defs.svh"
`timescale 1ns/1ps

module front_end_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load_mode,           // loader active
    input  logic                 load_we,
    input  pipe_pkg::imem_addr_t load_addr,
    input  pipe_pkg::word_t      load_data,
    input  pipe_pkg::wb_bus_t    wb,                  // from write-back stage
    input  logic                 hold,                // from hazard unit
    output pipe_pkg::id_ex_t     id_ex
);

    pipe_pkg::word_t       if_pc;                     // pc + 4
    pipe_pkg::word_t       if_instruction;
    logic                  if_no_op;
    pipe_pkg::word_t       id_pc;
    pipe_pkg::word_t       id_instruction;
    logic                  id_no_op;
    pipe_pkg::word_t       rs_data;
    pipe_pkg::word_t       rt_data;
    pipe_pkg::inst_class_t inst_class;
    pipe_pkg::alu_op_t     alu_op;
    pipe_pkg::mem_ctrl_t   mem_ctrl;
    logic                  wb_en;
    pipe_pkg::redirect_t   redirect;                  // to pc and if/id squash
    pipe_pkg::word_t       operand_1;
    pipe_pkg::word_t       operand_2;
    pipe_pkg::word_t       store_data;
    pipe_pkg::reg_idx_t    rs_idx;
    pipe_pkg::reg_idx_t    rt_idx;
    pipe_pkg::reg_idx_t    dest_idx;
    pipe_pkg::id_ex_t      decoded;                   // bundle into id/ex

    assign decoded = '{valid: !id_no_op, alu_op: alu_op, mem_ctrl: mem_ctrl, wb_en: wb_en,
                       operand_1: operand_1, operand_2: operand_2, store_data: store_data,
                       rs_idx: rs_idx, rt_idx: rt_idx, dest_idx: dest_idx};

    instruction_mem instruction_mem (
        .clk(clk), .arst_n(arst_n),
        .load_mode(load_mode), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .redirect(redirect), .hold(hold),
        .if_pc(if_pc), .if_instruction(if_instruction), .if_no_op(if_no_op)
    );

    if_id_reg if_id_reg (
        .clk(clk), .arst_n(arst_n), .hold(hold), .squash(redirect.taken),
        .if_pc(if_pc), .if_instruction(if_instruction), .if_no_op(if_no_op),
        .id_pc(id_pc), .id_instruction(id_instruction), .id_no_op(id_no_op)
    );

    register_file register_file (
        .clk(clk), .arst_n(arst_n),
        .rs_idx(id_instruction[`RS_LSB +: `REG_ADDR_WIDTH]),    // rs 25:21
        .rt_idx(id_instruction[`RT_LSB +: `REG_ADDR_WIDTH]),    // rt 20:16
        .wb(wb), .rs_data(rs_data), .rt_data(rt_data)
    );

    control control (
        .id_instruction(id_instruction),
        .inst_class(inst_class), .alu_op(alu_op), .mem_ctrl(mem_ctrl), .wb_en(wb_en)
    );

    operand_select operand_select (
        .inst_class(inst_class), .id_pc(id_pc), .id_instruction(id_instruction),
        .id_no_op(id_no_op), .rs_data(rs_data), .rt_data(rt_data),
        .redirect(redirect), .operand_1(operand_1), .operand_2(operand_2),
        .store_data(store_data), .rs_idx_out(rs_idx), .rt_idx_out(rt_idx), .dest_idx(dest_idx)
    );

    id_ex_reg id_ex_reg (
        .clk(clk), .arst_n(arst_n), .hold(hold), .decoded(decoded), .id_ex(id_ex)
    );

endmodule

//--- test/front_end_checker.sv
`timescale 1ns/1ps

module front_end_checker (
    input logic                clk,
    input logic                arst_n,
    input logic                hold,
    input pipe_pkg::redirect_t redirect,
    input pipe_pkg::id_ex_t    id_ex
);

    int fail_count = 0;                                // failed assertions so far

    // squashed slot reaches id_ex two edges after the redirect
    squash_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.taken |-> ##2 !id_ex.valid)
    else begin
        fail_count++;
        $error("a redirect was followed by a valid id_ex entry");
    end

    hold_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        hold |=> !id_ex.valid)                        // bubble captured on the held edge
    else begin
        fail_count++;
        $error("id_ex was valid after a hold cycle");
    end

    no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        id_ex.wb_en |-> id_ex.dest_idx != '0)
    else begin
        fail_count++;
        $error("id_ex writes back to register 0");
    end

endmodule

bind front_end_top front_end_checker checks (
    .clk(clk), .arst_n(arst_n), .hold(hold), .redirect(redirect), .id_ex(id_ex)
);

//--- test/front_end_tb.sv
`timescale 1ns/1ps

module front_end_tb;

    localparam int    MAX_RECORDS = 128;
    localparam int    MAX_FIELDS  = 10;
    localparam string CASE_FILE   = "test/front_end_cases.txt";

    logic                 clk;
    logic                 arst_n;
    logic                 load_mode;
    logic                 load_we;
    pipe_pkg::imem_addr_t load_addr;
    pipe_pkg::word_t      load_data;
    pipe_pkg::wb_bus_t    wb;
    logic                 hold;
    pipe_pkg::id_ex_t     id_ex;

    byte               rec_kind [0:MAX_RECORDS-1];                // L W R H E
    pipe_pkg::word_t   rec_field [0:MAX_RECORDS-1][0:MAX_FIELDS-1];
    int                rec_count;
    int                cycle_limit;                               // record cycles + 50
    int                cycle_count = 0;
    int                error_count = 0;
    pipe_pkg::wb_bus_t wb_pending;                                // goes out with next cycle
    logic              load_active;                               // load_mode to drive

    front_end_top dut_i (
        .clk(clk), .arst_n(arst_n), .load_mode(load_mode), .load_we(load_we),
        .load_addr(load_addr), .load_data(load_data), .wb(wb), .hold(hold), .id_ex(id_ex)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the case file did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic read_cases();
        int              fd;
        int              code;
        int              n_fields;
        byte             kind;
        pipe_pkg::word_t value;
        logic [1023:0]   skipped;
        fd        = $fopen(CASE_FILE, "r");
        rec_count = 0;
        if (fd == 0) begin
            error_count++;
            $display("could not open the case file %s", CASE_FILE);
        end else begin
            cycle_limit = 50;
            while (rec_count < MAX_RECORDS) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) break;                             // end of file
                case (kind)
                    "#":     n_fields = -1;                       // comment line
                    "L":     n_fields = 2;
                    "W":     n_fields = 2;
                    "R":     n_fields = 1;
                    "H":     n_fields = 1;
                    "E":     n_fields = MAX_FIELDS;
                    default: n_fields = -2;
                endcase
                if (n_fields == -1) begin
                    code = $fgets(skipped, fd);
                end else if (n_fields == -2) begin
                    error_count++;
                    $display("the case file holds an unknown record kind %c", kind);
                end else begin
                    rec_kind[rec_count] = kind;
                    for (int i = 0; i < n_fields; i++) begin
                        code = $fscanf(fd, " %h", value);
                        rec_field[rec_count][i] = value;
                    end
                    if (kind == "R" || kind == "H") begin
                        cycle_limit += rec_field[rec_count][0];
                    end else if (kind != "W") begin
                        cycle_limit += 1;                         // L and E take one cycle
                    end
                    rec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // all inputs driven on one rising edge
    task automatic drive_cycle(input logic we, input pipe_pkg::imem_addr_t addr,
                               input pipe_pkg::word_t data, input logic stall);
        @(posedge clk);
        load_we   <= we;
        load_addr <= addr;
        load_data <= data;
        hold      <= stall;
        load_mode <= load_active;
        wb        <= wb_pending;
        wb_pending = '0;                                          // one cycle of write-back
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t got,
                              input pipe_pkg::word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bundle(input pipe_pkg::id_ex_t got, input pipe_pkg::id_ex_t exp);
        pipe_pkg::id_ex_t got_ctrl;
        pipe_pkg::id_ex_t exp_ctrl;
        got_ctrl = got;
        exp_ctrl = exp;
        got_ctrl.operand_1  = '0;                                 // words compared below
        got_ctrl.operand_2  = '0;
        got_ctrl.store_data = '0;
        exp_ctrl.operand_1  = '0;
        exp_ctrl.operand_2  = '0;
        exp_ctrl.store_data = '0;
        if (got_ctrl !== exp_ctrl) begin
            error_count++;
            $display("error id_ex controls at cycle %0d: got %h expected %h",
                     cycle_count, got_ctrl, exp_ctrl);
        end
        check_word("id_ex.operand_1", got.operand_1, exp.operand_1);
        check_word("id_ex.operand_2", got.operand_2, exp.operand_2);
        check_word("id_ex.store_data", got.store_data, exp.store_data);
    endtask

    task automatic run_record(input int r);
        pipe_pkg::id_ex_t exp;
        case (rec_kind[r])
            "L": drive_cycle(1'b1, pipe_pkg::imem_addr_t'(rec_field[r][0]), rec_field[r][1],
                             1'b0);
            "W": wb_pending = '{en: 1'b1, addr: pipe_pkg::reg_idx_t'(rec_field[r][0]),
                                data: rec_field[r][1]};
            "R", "H": begin
                load_active = 1'b0;                               // loading ends here
                repeat (rec_field[r][0]) drive_cycle(1'b0, '0, '0, rec_kind[r] == "H");
            end
            "E": begin
                drive_cycle(1'b0, '0, '0, 1'b0);
                @(negedge clk);                                   // id_ex settled
                exp.valid      = rec_field[r][0][0];
                exp.alu_op     = pipe_pkg::alu_op_t'(rec_field[r][1][2:0]);
                exp.mem_ctrl   = pipe_pkg::mem_ctrl_t'(rec_field[r][2][1:0]);
                exp.wb_en      = rec_field[r][3][0];
                exp.operand_1  = rec_field[r][4];
                exp.operand_2  = rec_field[r][5];
                exp.store_data = rec_field[r][6];
                exp.rs_idx     = pipe_pkg::reg_idx_t'(rec_field[r][7]);
                exp.rt_idx     = pipe_pkg::reg_idx_t'(rec_field[r][8]);
                exp.dest_idx   = pipe_pkg::reg_idx_t'(rec_field[r][9]);
                check_bundle(id_ex, exp);
            end
            default: ;
        endcase
    endtask

    initial begin
        arst_n      = 1'b0;
        load_mode   = 1'b1;                                       // loader owns the rom first
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        wb          = '0;
        hold        = 1'b0;
        wb_pending  = '0;
        load_active = 1'b1;
        cycle_limit = 1000;
        read_cases();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int r = 0; r < rec_count; r++) begin
            run_record(r);
        end
        $display("%0d compare errors, %0d assertion failures",
                 error_count, dut_i.checks.fail_count);
        if (error_count == 0 && dut_i.checks.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- test/front_end_cases.txt
# records: L addr word, W reg value (goes out with the next cycle), R cycles, H cycles
# E valid alu_op mem_ctrl wb_en operand_1 operand_2 store_data rs rt dest, all hex
W 01 00000005  L 00 00222020
W 02 00000005  L 01 2025fffc
W 03 00000007  L 02 ac230008
W 08 00000040  L 03 10230004
W 00 deadbeef  L 04 10220002
L 05 00233822  L 07 14220005  L 08 0c00000c  L 09 00233822
L 0c 14230001  L 0d 00233822  L 0e 01000008  L 0f 00233822
L 10 08000014  L 11 00233822
L 14 00235825  L 15 000a4820  L 16 0061602a  L 17 8d0dfff8
# still loading, then restart from pc 0
E 0 0 0 0 00000000 00000000 00000000 00 00 00
R 1
E 0 0 0 0 00000000 00000000 00000000 00 00 00
E 0 0 0 0 00000000 00000000 00000000 00 00 00
# add, addi, sw
E 1 0 0 1 00000005 00000005 00000000 01 02 04
E 1 0 0 1 00000005 fffffffc 00000000 01 00 05
E 1 0 2 0 00000005 00000008 00000007 01 03 00
# beq not taken, beq taken to 1c, bne not taken
E 1 5 0 0 00000000 00000000 00000000 01 03 00
E 1 5 0 0 00000000 00000000 00000000 01 02 00
E 0 0 0 0 00000000 00000000 00000000 00 00 00
E 1 5 0 0 00000000 00000000 00000000 01 02 00
# jal to 30, bne taken to 38, jr r8 to 40, j to 50
E 1 5 0 1 00000024 00000000 00000000 00 00 1f
E 0 0 0 0 00000000 00000000 00000000 00 00 00
E 1 5 0 0 00000000 00000000 00000000 01 03 00
E 0 0 0 0 00000000 00000000 00000000 00 00 00
E 1 5 0 0 00000000 00000000 00000000 08 00 00
E 0 0 0 0 00000000 00000000 00000000 00 00 00
E 1 5 0 0 00000000 00000000 00000000 00 00 00
# hold with or in decode, then bypass of r10 into add r9, r0, r10
H 2
E 0 0 0 0 00000000 00000000 00000000 00 00 00
W 0a 1234abcd
E 1 3 0 1 00000005 00000007 00000000 01 03 0b
E 1 0 0 1 00000000 1234abcd 00000000 00 0a 09
E 1 4 0 1 00000007 00000005 00000000 03 01 0c
E 1 0 1 1 00000040 fffffff8 00000000 08 00 0d

//--- verilog.f
+incdir+include
hdl/pipe_pkg.sv
hdl/instruction_mem.sv
hdl/if_id_reg.sv
hdl/register_file.sv
hdl/control.sv
hdl/operand_select.sv
hdl/id_ex_reg.sv
hdl/front_end_top.sv
test/front_end_checker.sv
test/front_end_tb.sv

//--- run.sh
#!/bin/sh
# compile and run front_end_tb with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module front_end_tb -f verilog.f \
    -o front_end_sim && obj_dir/front_end_sim +verilator+error+limit+100 | tee sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
